/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_spmv
FILELIST := tb.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then exit 1; fi
	@grep -q '>>> PASS' $(LOG)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/nz_fifo.sv */
`timescale 1ns/1ns

module nz_fifo
  import spmv_pkg::*;
#(
  parameter int NZ_DEPTH = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push_i,
  input  nz_t  data_i,
  input  logic pop_i,
  output nz_t  data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int PW = $clog2(NZ_DEPTH);
  localparam int CW = $clog2(NZ_DEPTH + 1);

  nz_t           mem [NZ_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PW'(NZ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(NZ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // head falls through
  assign data_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o  = (count == CW'(NZ_DEPTH));

endmodule

/* design/result_buf.sv */
`timescale 1ns/1ns

module result_buf
  import spmv_pkg::*;
#(
  parameter int RES_DEPTH = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_i,
  input  acc_t       data_i,
  input  logic       pop_i,
  output acc_t       data_o,
  output logic       empty_o,
  output logic       full_o,
  output logic [3:0] count_o
);

  localparam int PW = $clog2(RES_DEPTH);
  localparam int CW = $clog2(RES_DEPTH + 1);

  acc_t          slots [RES_DEPTH];
  logic [PW-1:0] head;
  logic [PW-1:0] tail;
  logic [CW-1:0] used;
  logic          wr_en;
  logic          rd_en;

  assign wr_en = push_i && !full_o;
  assign rd_en = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      used <= '0;
    end else begin
      if (wr_en) begin
        tail <= (tail == PW'(RES_DEPTH - 1)) ? '0 : tail + 1'b1;
      end
      if (rd_en) begin
        head <= (head == PW'(RES_DEPTH - 1)) ? '0 : head + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      slots[tail] <= data_i;
    end
  end

  assign data_o  = slots[head];
  assign empty_o = (used == '0);
  assign full_o  = (used == CW'(RES_DEPTH));
  // occupancy for the status word
  assign count_o = 4'(used);

endmodule

/* design/sp_pe.sv */
`timescale 1ns/1ns

module sp_pe
  import spmv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start_i,
  input  len_t  row_len_i,
  input  nz_t   nz_i,
  input  logic  nz_empty_i,
  input  data_t weight_i,
  input  logic  res_full_i,
  output logic  nz_pop_o,
  output col_t  waddr_o,
  output logic  res_push_o,
  output acc_t  result_o,
  output logic  busy_o
);

  pe_state_t state_q;
  pe_state_t state_d;
  len_t      len_q;
  len_t      cnt_q;
  prod_t     prod_q;
  logic      prod_vld_q;
  acc_t      acc_q;
  logic      drain_q;
  logic      pop;
  logic      last_pop;
  logic      load;
  data_t     value;
  logic [$bits(acc_t):0] sum;

  assign value   = nz_i[7:0];
  assign waddr_o = nz_i[13:8];

  assign load     = (state_q == IDLE) && start_i;
  assign pop      = (state_q == RUN) && !nz_empty_i && (cnt_q < len_q);
  assign last_pop = pop && ((cnt_q + 7'd1) == len_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        // an empty row goes straight to drain
        if (last_pop || (cnt_q == len_q)) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (drain_q) begin
          state_d = DONE;
        end
      end
      DONE: begin
        if (!res_full_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      len_q      <= '0;
      cnt_q      <= '0;
      prod_vld_q <= 1'b0;
      drain_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      prod_vld_q <= pop;
      // second drain cycle lets the last product land in acc
      drain_q    <= (state_q == DRAIN) && !drain_q;
      if (load) begin
        len_q <= row_len_i;
        cnt_q <= '0;
      end else if (pop) begin
        cnt_q <= cnt_q + 7'd1;
      end
    end
  end

  // stage 2 sum, carry out means overflow
  assign sum = {1'b0, acc_q} + {1'b0, prod_q};

  always_ff @(posedge clk) begin
    // stage 1
    if (pop) begin
      prod_q <= prod_t'(value) * prod_t'(weight_i);
    end
    if (load) begin
      acc_q <= '0;
    end else if (prod_vld_q) begin
      acc_q <= sum[$bits(acc_t)] ? '1 : sum[$bits(acc_t)-1:0];
    end
  end

  assign nz_pop_o   = pop;
  assign res_push_o = (state_q == DONE) && !res_full_i;
  assign result_o   = acc_q;
  assign busy_o     = (state_q != IDLE);

endmodule

/* design/spmv_pkg.sv */
package spmv_pkg;

  // feature values and weights
  typedef logic [7:0]  data_t;
  // unsigned product of two data_t
  typedef logic [15:0] prod_t;
  // accumulator, clamps to all ones
  typedef logic [15:0] acc_t;
  // column index into a 64 entry weight vector
  typedef logic [5:0]  col_t;
  // nonzero count of a row, 0 to 64
  typedef logic [6:0]  len_t;
  // nonzero entry, column on top and value below
  typedef logic [13:0] nz_t;
  typedef logic [31:0] wb_dat_t;

  // address regions on adr[9:8]
  localparam logic [1:0] REG_WEIGHT = 2'd0;
  localparam logic [1:0] REG_NZ     = 2'd1;
  localparam logic [1:0] REG_CTRL   = 2'd2;
  localparam logic [1:0] REG_RESULT = 2'd3;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } pe_state_t;

endpackage

/* design/spmv_top.sv */
`timescale 1ns/1ns

module spmv_top
  import spmv_pkg::*;
#(
  parameter int DOT_SIZE  = 64,
  parameter int NZ_DEPTH  = 16,
  parameter int RES_DEPTH = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  input  logic       wb_we_i,
  input  logic [9:0] wb_adr_i,
  input  wb_dat_t    wb_dat_i,
  output wb_dat_t    wb_dat_o,
  output logic       wb_ack_o
);

  // weight store write side
  logic  w_we;
  col_t  w_addr;
  data_t w_data;
  // nonzero fifo
  logic  nz_push;
  nz_t   nz_wdata;
  logic  nz_pop;
  nz_t   nz_head;
  logic  nz_empty;
  logic  nz_full;
  // execute
  logic  row_start;
  len_t  row_len;
  col_t  pe_raddr;
  data_t pe_weight;
  logic  pe_busy;
  // result buffer
  logic       res_push;
  acc_t       res_wdata;
  logic       res_pop;
  acc_t       res_head;
  logic       res_empty;
  logic       res_full;
  logic [3:0] res_count;

  wb_decode u_wb_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .fifo_full_i (nz_full),
    .pe_busy_i   (pe_busy),
    .res_count_i (res_count),
    .res_data_i  (res_head),
    .res_empty_i (res_empty),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .w_we_o      (w_we),
    .w_addr_o    (w_addr),
    .w_data_o    (w_data),
    .nz_push_o   (nz_push),
    .nz_data_o   (nz_wdata),
    .row_start_o (row_start),
    .row_len_o   (row_len),
    .res_pop_o   (res_pop)
  );

  nz_fifo #(
    .NZ_DEPTH (NZ_DEPTH)
  ) u_nz_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (nz_push),
    .data_i  (nz_wdata),
    .pop_i   (nz_pop),
    .data_o  (nz_head),
    .empty_o (nz_empty),
    .full_o  (nz_full)
  );

  weight_mem #(
    .DOT_SIZE (DOT_SIZE)
  ) u_weight_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (w_we),
    .waddr_i (w_addr),
    .wdata_i (w_data),
    .raddr_i (pe_raddr),
    .rdata_o (pe_weight)
  );

  sp_pe u_sp_pe (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (row_start),
    .row_len_i  (row_len),
    .nz_i       (nz_head),
    .nz_empty_i (nz_empty),
    .weight_i   (pe_weight),
    .res_full_i (res_full),
    .nz_pop_o   (nz_pop),
    .waddr_o    (pe_raddr),
    .res_push_o (res_push),
    .result_o   (res_wdata),
    .busy_o     (pe_busy)
  );

  result_buf #(
    .RES_DEPTH (RES_DEPTH)
  ) u_result_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (res_push),
    .data_i  (res_wdata),
    .pop_i   (res_pop),
    .data_o  (res_head),
    .empty_o (res_empty),
    .full_o  (res_full),
    .count_o (res_count)
  );

endmodule

/* design/wb_decode.sv */
`timescale 1ns/1ns

module wb_decode
  import spmv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  input  logic       wb_we_i,
  input  logic [9:0] wb_adr_i,
  input  wb_dat_t    wb_dat_i,
  input  logic       fifo_full_i,
  input  logic       pe_busy_i,
  input  logic [3:0] res_count_i,
  input  acc_t       res_data_i,
  input  logic       res_empty_i,
  output wb_dat_t    wb_dat_o,
  output logic       wb_ack_o,
  output logic       w_we_o,
  output col_t       w_addr_o,
  output data_t      w_data_o,
  output logic       nz_push_o,
  output nz_t        nz_data_o,
  output logic       row_start_o,
  output len_t       row_len_o,
  output logic       res_pop_o
);

  logic       ack_q;
  logic       req;
  logic       go;
  logic [1:0] region;
  wb_dat_t    rd_word;

  assign region = wb_adr_i[9:8];
  // no new request in the ack cycle, the master is still holding the old one
  assign req = wb_cyc_i && wb_stb_i && !ack_q;

  // back-pressure on pushes and row starts
  always_comb begin
    case (region)
      REG_NZ:   go = req && (!wb_we_i || !fifo_full_i);
      REG_CTRL: go = req && (!wb_we_i || !pe_busy_i);
      default:  go = req;
    endcase
  end

  always_comb begin
    case (region)
      REG_CTRL:   rd_word = {fifo_full_i, pe_busy_i, 26'd0, res_count_i};
      REG_RESULT: rd_word = {!res_empty_i, 15'd0, res_data_i};
      default:    rd_word = '0;
    endcase
  end

  // side effects fire together with ack
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q       <= 1'b0;
      w_we_o      <= 1'b0;
      nz_push_o   <= 1'b0;
      row_start_o <= 1'b0;
      res_pop_o   <= 1'b0;
    end else begin
      ack_q       <= go;
      w_we_o      <= go && wb_we_i && (region == REG_WEIGHT);
      nz_push_o   <= go && wb_we_i && (region == REG_NZ);
      row_start_o <= go && wb_we_i && (region == REG_CTRL);
      res_pop_o   <= go && !wb_we_i && (region == REG_RESULT) && !res_empty_i;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      w_addr_o  <= wb_adr_i[5:0];
      w_data_o  <= wb_dat_i[7:0];
      nz_data_o <= {wb_dat_i[21:16], wb_dat_i[7:0]};
      row_len_o <= wb_dat_i[6:0];
      wb_dat_o  <= rd_word;
    end
  end

  assign wb_ack_o = ack_q;

endmodule

/* design/weight_mem.sv */
`timescale 1ns/1ns

module weight_mem
  import spmv_pkg::*;
#(
  parameter int DOT_SIZE = 64
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  we_i,
  input  col_t  waddr_i,
  input  data_t wdata_i,
  input  col_t  raddr_i,
  output data_t rdata_o
);

  data_t weights [DOT_SIZE];

  // weights read as zero until loaded
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DOT_SIZE; i++) begin
        weights[i] <= '0;
      end
    end else if (we_i) begin
      weights[waddr_i] <= wdata_i;
    end
  end

  // same-cycle lookup for the execute stage
  assign rdata_o = weights[raddr_i];

endmodule

/* tb.f */
design/spmv_pkg.sv
design/wb_decode.sv
design/nz_fifo.sv
design/weight_mem.sv
design/sp_pe.sv
design/result_buf.sv
design/spmv_top.sv
test/tb_clk_gen.sv
test/tb_spmv.sv

/* test/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // low across the first two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

/* test/tb_spmv.sv */
`timescale 1ns/1ns

module tb_spmv
  import spmv_pkg::*;
();

  localparam int NUM_TESTS   = 6;
  localparam int CLK_NS      = 40;
  localparam int WATCHDOG_NS = NUM_TESTS * 2000 * CLK_NS;
  localparam int ACK_LIMIT   = 200;

  logic       clk;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [9:0] wb_adr;
  wb_dat_t    wb_dat_w;
  wb_dat_t    wb_dat_r;
  logic       wb_ack;

  integer      seed = 32'h03ea_ad42;
  int          value_errors = 0;
  int          other_errors = 0;
  int          ack_wait;
  logic        ack_prev;
  data_t       weights_ref [64];
  int unsigned expect_q [$];

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  spmv_top u_spmv_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  // one classic cycle that ends after the ack cycle or after max_wait edges
  task automatic bus_cycle(input logic we, input logic [9:0] adr, input wb_dat_t wdat,
                           input int max_wait, output logic acked, output wb_dat_t rdat);
    int n;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    acked    = 1'b0;
    n        = 0;
    while (!acked && n < max_wait) begin
      @(posedge clk);
      #1;
      n++;
      acked = wb_ack;
    end
    rdat     = wb_dat_r;
    ack_wait = n;
    // the master still holds its request during the ack cycle
    if (acked) begin
      @(posedge clk);
      #1;
    end
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
  endtask

  task automatic wb_write(input logic [9:0] adr, input wb_dat_t wdat);
    logic    acked;
    wb_dat_t unused;
    bus_cycle(1'b1, adr, wdat, ACK_LIMIT, acked, unused);
    if (!acked) begin
      $display("write to address %h got no ack within %0d cycles", adr, ACK_LIMIT);
      other_errors++;
    end
  endtask

  task automatic wb_read(input logic [9:0] adr, output wb_dat_t rdat);
    logic acked;
    bus_cycle(1'b0, adr, 32'd0, ACK_LIMIT, acked, rdat);
    if (!acked) begin
      $display("read from address %h got no ack within %0d cycles", adr, ACK_LIMIT);
      other_errors++;
    end
  endtask

  // unsigned product added with every partial sum clamped at 65535
  function automatic int unsigned sat_add(input int unsigned acc, input data_t value,
                                          input data_t weight);
    int unsigned sum;
    sum = acc + 32'(value) * 32'(weight);
    if (sum > 32'd65535) begin
      sum = 32'd65535;
    end
    return sum;
  endfunction

  task automatic load_weight(input col_t col, input data_t val);
    wb_write({REG_WEIGHT, 2'b00, col}, 32'(val));
    weights_ref[col] = val;
  endtask

  task automatic load_random_weights();
    for (int i = 0; i < 64; i++) begin
      load_weight(col_t'(i), data_t'($random(seed)));
    end
  endtask

  task automatic push_nz(input col_t col, input data_t val);
    wb_write({REG_NZ, 8'h00}, {10'd0, col, 8'd0, val});
  endtask

  task automatic rand_entry(output col_t col, output data_t val);
    col = col_t'($random(seed));
    val = data_t'($random(seed));
  endtask

  task automatic push_random(input int n, inout int unsigned acc);
    col_t  col;
    data_t val;
    for (int i = 0; i < n; i++) begin
      rand_entry(col, val);
      push_nz(col, val);
      acc = sat_add(acc, val, weights_ref[col]);
    end
  endtask

  task automatic start_row(input len_t len);
    wb_write({REG_CTRL, 8'h00}, 32'(len));
  endtask

  task automatic read_status(output wb_dat_t word);
    wb_read({REG_CTRL, 8'h00}, word);
  endtask

  // polls the status word until the result count reaches target
  task automatic wait_count(input int target);
    wb_dat_t word;
    int      polls;
    polls = 0;
    read_status(word);
    while (int'(word[3:0]) < target && polls < 300) begin
      read_status(word);
      polls++;
    end
    if (int'(word[3:0]) < target) begin
      $display("result count never reached %0d", target);
      other_errors++;
    end
  endtask

  task automatic read_and_check(input string name, input int unsigned expected);
    wb_dat_t word;
    wb_read({REG_RESULT, 8'h00}, word);
    check_value(name, {16'h8000, 16'(expected)}, word);
  endtask

  // ack is a single-cycle pulse
  initial begin
    ack_prev = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      assert (!(ack_prev && wb_ack))
      else begin
        $display("ack stayed high for more than one cycle");
        other_errors++;
      end
      ack_prev = wb_ack;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int unsigned acc;
    int unsigned len;
    wb_dat_t     word;
    logic        acked;
    col_t        col;
    data_t       val;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    @(posedge rst_n);

    // test 1 reset state
    read_status(word);
    check_value("reset_status", 32'd0, word);
    wb_read({REG_RESULT, 8'h00}, word);
    check_value("reset_result_valid", 32'd0, 32'(word[31]));

    // test 2 random rows against the reference model
    load_random_weights();
    repeat (5) begin
      len = 1 + ({$random(seed)} % 10);
      acc = 0;
      push_random(int'(len), acc);
      start_row(len_t'(len));
      wait_count(1);
      read_and_check("dot_product", acc);
    end

    // test 3 clamp and empty row
    for (int i = 0; i < 64; i++) begin
      load_weight(col_t'(i), 8'hff);
    end
    for (int i = 0; i < 8; i++) begin
      push_nz(col_t'(i), 8'hff);
    end
    start_row(7'd8);
    wait_count(1);
    read_and_check("saturation", 65535);
    start_row(7'd0);
    wait_count(1);
    read_and_check("zero_length", 0);

    // test 4 four rows queued before any read
    load_random_weights();
    expect_q.delete();
    repeat (4) begin
      acc = 0;
      push_random(3, acc);
      start_row(7'd3);
      expect_q.push_back(acc);
    end
    wait_count(4);
    read_status(word);
    check_value("order_count", 32'd4, 32'(word[3:0]));
    while (expect_q.size() > 0) begin
      read_and_check("order", expect_q.pop_front());
    end

    // small weights keep the long rows below the clamp
    for (int i = 0; i < 64; i++) begin
      load_weight(col_t'(i), data_t'($random(seed)) & 8'h0f);
    end

    // test 5 the extra push is held off until a row drains the full fifo
    acc = 0;
    push_random(16, acc);
    read_status(word);
    check_value("full_flag", 32'd1, 32'(word[31]));
    rand_entry(col, val);
    bus_cycle(1'b1, {REG_NZ, 8'h00}, {10'd0, col, 8'd0, val}, 8, acked, word);
    check_value("push_held_while_full", 32'd0, 32'(acked));
    start_row(7'd20);
    push_nz(col, val);
    acc = sat_add(acc, val, weights_ref[col]);
    push_random(3, acc);
    wait_count(1);
    read_and_check("backpressure", acc);

    // test 6 second start arrives while the first row is still running
    acc = 0;
    start_row(7'd4);
    read_status(word);
    check_value("busy_flag", 32'd1, 32'(word[30]));
    push_random(4, acc);
    expect_q.push_back(acc);
    start_row(7'd3);
    check_value("start_held", 32'd1, 32'(ack_wait > 1));
    read_status(word);
    check_value("first_result_before_start", 32'd1, 32'(word[3:0]));
    acc = 0;
    push_random(3, acc);
    expect_q.push_back(acc);
    wait_count(2);
    while (expect_q.size() > 0) begin
      read_and_check("busy_start", expect_q.pop_front());
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
